/* hw/cmac_mon_pkg.sv */
package cmac_mon_pkg;

    localparam int CNT_W = 32;

    typedef logic [CNT_W-1:0] cnt_t;

    // One cycle of a MAC stream, data and keep not carried
    typedef struct packed {
        logic valid;
        logic ready;
        logic last;
        logic user;
    } axis_beat_t;

    typedef struct packed {
        logic idle;
        cnt_t pkt_cnt;
        cnt_t beat_cnt;
        cnt_t lost_beat_cnt;
        cnt_t bad_fcs_cnt;
        cnt_t max_pkt_beats;
    } rx_stats_t;

    typedef struct packed {
        logic idle;
        cnt_t pkt_cnt;
        cnt_t beat_cnt;
        cnt_t max_pkt_beats;
        cnt_t overflow_cnt;
        cnt_t underflow_cnt;
    } tx_stats_t;

    typedef enum logic [1:0] {
        LINK_DOWN     = 2'd0,
        LINK_UP       = 2'd1,
        LINK_DEGRADED = 2'd2,
        LINK_FAULT    = 2'd3
    } link_state_e;

    // Counters stick at all-ones
    function automatic cnt_t sat_inc(cnt_t value);
        return (value == '1) ? value : value + cnt_t'(1);
    endfunction

    function automatic cnt_t sat_add(cnt_t value, cnt_t delta);
        logic [CNT_W:0] sum;
        sum = {1'b0, value} + {1'b0, delta};
        return sum[CNT_W] ? '1 : sum[CNT_W-1:0];
    endfunction

endpackage

/* hw/cmac_rx_monitor.sv */
`timescale 1ns/1ps

module cmac_rx_monitor
    import cmac_mon_pkg::*;
(
    input  logic       gt_init_clk,
    input  logic       rst_n,
    input  axis_beat_t rx_beat,
    input  logic [2:0] bad_fcs,
    output rx_stats_t  rx_stats
);

    logic accepted;
    logic lost;
    cnt_t cur_pkt_beats;
    cnt_t pkt_beats;

    assign accepted = rx_beat.valid & rx_beat.ready;
    // Valid without ready means the MAC dropped the beat
    assign lost = rx_beat.valid & ~rx_beat.ready;

    // Size of the current packet including this beat
    assign pkt_beats = sat_inc(cur_pkt_beats);

    always_ff @(posedge gt_init_clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_pkt_beats <= '0;
        end else if (accepted) begin
            if (rx_beat.last) begin
                cur_pkt_beats <= '0;
            end else begin
                cur_pkt_beats <= pkt_beats;
            end
        end
    end

    always_ff @(posedge gt_init_clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_stats.idle          <= 1'b1;
            rx_stats.pkt_cnt       <= '0;
            rx_stats.beat_cnt      <= '0;
            rx_stats.lost_beat_cnt <= '0;
            rx_stats.bad_fcs_cnt   <= '0;
            rx_stats.max_pkt_beats <= '0;
        end else begin
            if (accepted) begin
                rx_stats.idle     <= rx_beat.last;
                rx_stats.beat_cnt <= sat_inc(rx_stats.beat_cnt);
            end
            if (accepted && rx_beat.last) begin
                rx_stats.pkt_cnt <= sat_inc(rx_stats.pkt_cnt);
                if (pkt_beats > rx_stats.max_pkt_beats) begin
                    rx_stats.max_pkt_beats <= pkt_beats;
                end
            end
            if (lost) begin
                rx_stats.lost_beat_cnt <= sat_inc(rx_stats.lost_beat_cnt);
            end
            // MAC reports several bad frames per cycle at most
            rx_stats.bad_fcs_cnt <= sat_add(rx_stats.bad_fcs_cnt, cnt_t'(bad_fcs));
        end
    end

    // Largest packet is always part of the beat total
    a_max_le_beats: assert property (
        @(posedge gt_init_clk) disable iff (!rst_n)
        rx_stats.max_pkt_beats <= rx_stats.beat_cnt
    ) else $error("rx max_pkt_beats above beat_cnt");

    a_no_unknown: assert property (
        @(posedge gt_init_clk) disable iff (!rst_n)
        !$isunknown(rx_stats)
    ) else $error("rx statistics unknown");

endmodule

/* hw/cmac_tx_monitor.sv */
`timescale 1ns/1ps

module cmac_tx_monitor
    import cmac_mon_pkg::*;
(
    input  logic       gt_init_clk,
    input  logic       rst_n,
    input  axis_beat_t tx_beat,
    input  logic       overflow,
    input  logic       underflow,
    output tx_stats_t  tx_stats
);

    logic accepted;
    cnt_t cur_pkt_beats;
    cnt_t pkt_beats;

    // Beats held off by ready are not sent yet
    assign accepted = tx_beat.valid & tx_beat.ready;
    assign pkt_beats = sat_inc(cur_pkt_beats);

    always_ff @(posedge gt_init_clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_pkt_beats <= '0;
        end else if (accepted) begin
            if (tx_beat.last) begin
                cur_pkt_beats <= '0;
            end else begin
                cur_pkt_beats <= pkt_beats;
            end
        end
    end

    always_ff @(posedge gt_init_clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_stats.idle          <= 1'b1;
            tx_stats.pkt_cnt       <= '0;
            tx_stats.beat_cnt      <= '0;
            tx_stats.max_pkt_beats <= '0;
            tx_stats.overflow_cnt  <= '0;
            tx_stats.underflow_cnt <= '0;
        end else begin
            if (accepted) begin
                tx_stats.idle     <= tx_beat.last;
                tx_stats.beat_cnt <= sat_inc(tx_stats.beat_cnt);
            end
            if (accepted && tx_beat.last) begin
                tx_stats.pkt_cnt <= sat_inc(tx_stats.pkt_cnt);
                if (pkt_beats > tx_stats.max_pkt_beats) begin
                    tx_stats.max_pkt_beats <= pkt_beats;
                end
            end
            // One count per MAC pulse
            if (overflow) begin
                tx_stats.overflow_cnt <= sat_inc(tx_stats.overflow_cnt);
            end
            if (underflow) begin
                tx_stats.underflow_cnt <= sat_inc(tx_stats.underflow_cnt);
            end
        end
    end

    // Every packet ends on a counted beat
    a_pkt_le_beats: assert property (
        @(posedge gt_init_clk) disable iff (!rst_n)
        tx_stats.pkt_cnt <= tx_stats.beat_cnt
    ) else $error("tx pkt_cnt above beat_cnt");

endmodule

/* hw/link_status.sv */
`timescale 1ns/1ps

module link_status
    import cmac_mon_pkg::*;
#(
    parameter int SYNC_STAGES = 3
) (
    input  logic        gt_init_clk,
    input  logic        rst_n,
    input  logic        rx_aligned,
    input  logic        qsfp_fault,
    input  rx_stats_t   rx_stats,
    input  tx_stats_t   tx_stats,
    output logic        aligned_indication,
    output logic        fault_indication,
    output link_state_e link_state,
    output logic        monitors_idle
);

    logic [SYNC_STAGES-1:0] aligned_sync;
    logic [SYNC_STAGES-1:0] fault_sync;
    logic                   error_seen;

    // Both levels come from outside this clock domain
    always_ff @(posedge gt_init_clk or negedge rst_n) begin
        if (!rst_n) begin
            aligned_sync <= '0;
            fault_sync   <= '0;
        end else begin
            aligned_sync <= {aligned_sync[SYNC_STAGES-2:0], rx_aligned};
            fault_sync   <= {fault_sync[SYNC_STAGES-2:0], qsfp_fault};
        end
    end

    assign aligned_indication = aligned_sync[SYNC_STAGES-1];
    assign fault_indication   = fault_sync[SYNC_STAGES-1];

    assign error_seen = (|rx_stats.lost_beat_cnt) | (|rx_stats.bad_fcs_cnt) |
                        (|tx_stats.overflow_cnt) | (|tx_stats.underflow_cnt);

    always_ff @(posedge gt_init_clk or negedge rst_n) begin
        if (!rst_n) begin
            link_state    <= LINK_DOWN;
            monitors_idle <= 1'b1;
        end else begin
            monitors_idle <= rx_stats.idle & tx_stats.idle;
            // Fault wins over everything else
            if (fault_indication) begin
                link_state <= LINK_FAULT;
            end else if (aligned_indication && error_seen) begin
                link_state <= LINK_DEGRADED;
            end else if (aligned_indication) begin
                link_state <= LINK_UP;
            end else begin
                link_state <= LINK_DOWN;
            end
        end
    end

    // State lags the synchronized fault by one register
    a_no_up_on_fault: assert property (
        @(posedge gt_init_clk) disable iff (!rst_n)
        fault_indication |=> link_state != LINK_UP
    ) else $error("link_state up while QSFP fault high");

endmodule

/* hw/cmac_link_monitor.sv */
`timescale 1ns/1ps

module cmac_link_monitor
    import cmac_mon_pkg::*;
#(
    parameter int SYNC_STAGES = 3
) (
    input  logic        gt_init_clk,
    input  logic        rst_n,
    input  axis_beat_t  rx_beat,
    input  axis_beat_t  tx_beat,
    input  logic [2:0]  rx_bad_fcs,
    input  logic        tx_overflow,
    input  logic        tx_underflow,
    input  logic        rx_aligned,
    input  logic        qsfp_fault,
    output rx_stats_t   rx_stats,
    output tx_stats_t   tx_stats,
    output link_state_e link_state,
    output logic        aligned_indication,
    output logic        fault_indication,
    output logic        monitors_idle
);

    cmac_rx_monitor u_rx_mon (
        .gt_init_clk (gt_init_clk),
        .rst_n       (rst_n),
        .rx_beat     (rx_beat),
        .bad_fcs     (rx_bad_fcs),
        .rx_stats    (rx_stats)
    );

    cmac_tx_monitor u_tx_mon (
        .gt_init_clk (gt_init_clk),
        .rst_n       (rst_n),
        .tx_beat     (tx_beat),
        .overflow    (tx_overflow),
        .underflow   (tx_underflow),
        .tx_stats    (tx_stats)
    );

    // Combines both monitors with the QSFP and alignment levels
    link_status #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_link_status (
        .gt_init_clk        (gt_init_clk),
        .rst_n              (rst_n),
        .rx_aligned         (rx_aligned),
        .qsfp_fault         (qsfp_fault),
        .rx_stats           (rx_stats),
        .tx_stats           (tx_stats),
        .aligned_indication (aligned_indication),
        .fault_indication   (fault_indication),
        .link_state         (link_state),
        .monitors_idle      (monitors_idle)
    );

endmodule

/* verification/tb_cmac_link_monitor.sv */
`timescale 1ns/1ps

module tb_cmac_link_monitor
    import cmac_mon_pkg::*;
();

    localparam int SYNC_STAGES = 3;

    logic        gt_init_clk;
    logic        rst_n;
    axis_beat_t  rx_beat;
    axis_beat_t  tx_beat;
    logic [2:0]  rx_bad_fcs;
    logic        tx_overflow;
    logic        tx_underflow;
    logic        rx_aligned;
    logic        qsfp_fault;
    rx_stats_t   rx_stats;
    tx_stats_t   tx_stats;
    link_state_e link_state;
    logic        aligned_indication;
    logic        fault_indication;
    logic        monitors_idle;

    // Reference model state
    rx_stats_t              m_rx;
    tx_stats_t              m_tx;
    cnt_t                   m_rx_cur;
    cnt_t                   m_tx_cur;
    logic [SYNC_STAGES-1:0] al_hist;
    logic [SYNC_STAGES-1:0] ft_hist;
    logic                   m_idle;
    logic                   m_err;
    link_state_e            m_state;

    int          errors;
    int          rx_left;
    int          tx_left;
    int          n;
    logic [31:0] lcg_state = 32'd8834;

    cmac_link_monitor #(
        .SYNC_STAGES (SYNC_STAGES)
    ) dut0 (
        .gt_init_clk        (gt_init_clk),
        .rst_n              (rst_n),
        .rx_beat            (rx_beat),
        .tx_beat            (tx_beat),
        .rx_bad_fcs         (rx_bad_fcs),
        .tx_overflow        (tx_overflow),
        .tx_underflow       (tx_underflow),
        .rx_aligned         (rx_aligned),
        .qsfp_fault         (qsfp_fault),
        .rx_stats           (rx_stats),
        .tx_stats           (tx_stats),
        .link_state         (link_state),
        .aligned_indication (aligned_indication),
        .fault_indication   (fault_indication),
        .monitors_idle      (monitors_idle)
    );

    initial begin
        gt_init_clk = 1'b0;
        forever #5 gt_init_clk = ~gt_init_clk;
    end

    function automatic logic [31:0] rand_below(logic [31:0] bound);
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {16'd0, lcg_state[31:16]} % bound;
    endfunction

    // Sticks at all-ones once the sum would wrap
    function automatic cnt_t sat_sum(cnt_t a, cnt_t b);
        return (a > ~b) ? '1 : a + b;
    endfunction

    task automatic report_mismatch(string name, cnt_t expected, cnt_t actual);
        errors++;
        $display("Fail %s expected %0d actual %0d", name, expected, actual);
    endtask

    assign m_err = (m_rx.lost_beat_cnt != '0) || (m_rx.bad_fcs_cnt != '0) ||
                   (m_tx.overflow_cnt != '0) || (m_tx.underflow_cnt != '0);

    always_ff @(posedge gt_init_clk or negedge rst_n) begin
        if (!rst_n) begin
            m_rx     <= '0;
            m_rx.idle <= 1'b1;
            m_tx     <= '0;
            m_tx.idle <= 1'b1;
            m_rx_cur <= '0;
            m_tx_cur <= '0;
            al_hist  <= '0;
            ft_hist  <= '0;
            m_idle   <= 1'b1;
            m_state  <= LINK_DOWN;
        end else begin
            if (rx_beat.valid && rx_beat.ready) begin
                m_rx.beat_cnt <= sat_sum(m_rx.beat_cnt, cnt_t'(1));
                m_rx.idle     <= rx_beat.last;
                m_rx_cur      <= rx_beat.last ? '0 : m_rx_cur + cnt_t'(1);
                if (rx_beat.last) begin
                    m_rx.pkt_cnt <= sat_sum(m_rx.pkt_cnt, cnt_t'(1));
                    if (m_rx_cur + cnt_t'(1) > m_rx.max_pkt_beats)
                        m_rx.max_pkt_beats <= m_rx_cur + cnt_t'(1);
                end
            end
            if (rx_beat.valid && !rx_beat.ready)
                m_rx.lost_beat_cnt <= sat_sum(m_rx.lost_beat_cnt, cnt_t'(1));
            m_rx.bad_fcs_cnt <= sat_sum(m_rx.bad_fcs_cnt, {{(CNT_W-3){1'b0}}, rx_bad_fcs});
            if (tx_beat.valid && tx_beat.ready) begin
                m_tx.beat_cnt <= sat_sum(m_tx.beat_cnt, cnt_t'(1));
                m_tx.idle     <= tx_beat.last;
                m_tx_cur      <= tx_beat.last ? '0 : m_tx_cur + cnt_t'(1);
                if (tx_beat.last) begin
                    m_tx.pkt_cnt <= sat_sum(m_tx.pkt_cnt, cnt_t'(1));
                    if (m_tx_cur + cnt_t'(1) > m_tx.max_pkt_beats)
                        m_tx.max_pkt_beats <= m_tx_cur + cnt_t'(1);
                end
            end
            if (tx_overflow)
                m_tx.overflow_cnt <= sat_sum(m_tx.overflow_cnt, cnt_t'(1));
            if (tx_underflow)
                m_tx.underflow_cnt <= sat_sum(m_tx.underflow_cnt, cnt_t'(1));
            al_hist <= {al_hist[SYNC_STAGES-2:0], rx_aligned};
            ft_hist <= {ft_hist[SYNC_STAGES-2:0], qsfp_fault};
            m_idle  <= m_rx.idle & m_tx.idle;
            if (ft_hist[SYNC_STAGES-1])
                m_state <= LINK_FAULT;
            else if (al_hist[SYNC_STAGES-1] && m_err)
                m_state <= LINK_DEGRADED;
            else if (al_hist[SYNC_STAGES-1])
                m_state <= LINK_UP;
            else
                m_state <= LINK_DOWN;
        end
    end

    // Checked mid-cycle, away from the rising edge
    a_rx_pkt: assert property (@(negedge gt_init_clk) rx_stats.pkt_cnt == m_rx.pkt_cnt)
        else report_mismatch("rx pkt_cnt", m_rx.pkt_cnt, rx_stats.pkt_cnt);
    a_rx_beat: assert property (@(negedge gt_init_clk) rx_stats.beat_cnt == m_rx.beat_cnt)
        else report_mismatch("rx beat_cnt", m_rx.beat_cnt, rx_stats.beat_cnt);
    a_rx_lost: assert property (@(negedge gt_init_clk)
        rx_stats.lost_beat_cnt == m_rx.lost_beat_cnt)
        else report_mismatch("rx lost_beat_cnt", m_rx.lost_beat_cnt, rx_stats.lost_beat_cnt);
    a_rx_fcs: assert property (@(negedge gt_init_clk) rx_stats.bad_fcs_cnt == m_rx.bad_fcs_cnt)
        else report_mismatch("rx bad_fcs_cnt", m_rx.bad_fcs_cnt, rx_stats.bad_fcs_cnt);
    a_rx_max: assert property (@(negedge gt_init_clk)
        rx_stats.max_pkt_beats == m_rx.max_pkt_beats)
        else report_mismatch("rx max_pkt_beats", m_rx.max_pkt_beats, rx_stats.max_pkt_beats);
    a_rx_idle: assert property (@(negedge gt_init_clk) rx_stats.idle == m_rx.idle)
        else report_mismatch("rx idle", cnt_t'(m_rx.idle), cnt_t'(rx_stats.idle));
    a_tx_pkt: assert property (@(negedge gt_init_clk) tx_stats.pkt_cnt == m_tx.pkt_cnt)
        else report_mismatch("tx pkt_cnt", m_tx.pkt_cnt, tx_stats.pkt_cnt);
    a_tx_beat: assert property (@(negedge gt_init_clk) tx_stats.beat_cnt == m_tx.beat_cnt)
        else report_mismatch("tx beat_cnt", m_tx.beat_cnt, tx_stats.beat_cnt);
    a_tx_max: assert property (@(negedge gt_init_clk)
        tx_stats.max_pkt_beats == m_tx.max_pkt_beats)
        else report_mismatch("tx max_pkt_beats", m_tx.max_pkt_beats, tx_stats.max_pkt_beats);
    a_tx_ovf: assert property (@(negedge gt_init_clk)
        tx_stats.overflow_cnt == m_tx.overflow_cnt)
        else report_mismatch("tx overflow_cnt", m_tx.overflow_cnt, tx_stats.overflow_cnt);
    a_tx_unf: assert property (@(negedge gt_init_clk)
        tx_stats.underflow_cnt == m_tx.underflow_cnt)
        else report_mismatch("tx underflow_cnt", m_tx.underflow_cnt, tx_stats.underflow_cnt);
    a_tx_idle: assert property (@(negedge gt_init_clk) tx_stats.idle == m_tx.idle)
        else report_mismatch("tx idle", cnt_t'(m_tx.idle), cnt_t'(tx_stats.idle));
    a_mon_idle: assert property (@(negedge gt_init_clk) monitors_idle == m_idle)
        else report_mismatch("monitors_idle", cnt_t'(m_idle), cnt_t'(monitors_idle));
    a_aligned: assert property (@(negedge gt_init_clk)
        aligned_indication == al_hist[SYNC_STAGES-1])
        else report_mismatch("aligned_indication", cnt_t'(al_hist[SYNC_STAGES-1]),
                             cnt_t'(aligned_indication));
    a_fault: assert property (@(negedge gt_init_clk) fault_indication == ft_hist[SYNC_STAGES-1])
        else report_mismatch("fault_indication", cnt_t'(ft_hist[SYNC_STAGES-1]),
                             cnt_t'(fault_indication));
    a_state: assert property (@(negedge gt_init_clk) link_state == m_state)
        else report_mismatch("link_state", cnt_t'(m_state), cnt_t'(link_state));

    // Next beat of a random packet stream, holding a beat until it is taken
    task automatic make_beat(inout int left, input logic more, input logic allow_lost,
                             output axis_beat_t beat);
        beat = '0;
        if (left == 0 && more)
            left = 1 + int'(rand_below(32'd8));
        if (left != 0) begin
            beat.valid = rand_below(32'd4) != 32'd0;
            beat.last  = (left == 1);
            beat.user  = beat.last && (rand_below(32'd8) == 32'd0);
        end
        beat.ready = rand_below(32'd4) != 32'd0;
        // No lost beat, a ready gap then holds valid low
        if (!allow_lost && !beat.ready)
            beat.valid = 1'b0;
        if (beat.valid && beat.ready)
            left = left - 1;
    endtask

    task automatic drive_cycle(input logic more, input logic inject,
                               input logic aligned, input logic fault);
        axis_beat_t  rb;
        axis_beat_t  xb;
        logic [31:0] r;
        logic [31:0] fcs;
        @(negedge gt_init_clk);
        make_beat(rx_left, more, inject, rb);
        make_beat(tx_left, more, 1'b1, xb);
        rx_beat      = rb;
        tx_beat      = xb;
        rx_aligned   = aligned;
        qsfp_fault   = fault;
        r            = rand_below(32'd32);
        fcs          = rand_below(32'd7) + 32'd1;
        rx_bad_fcs   = (inject && r == 32'd0) ? fcs[2:0] : 3'd0;
        tx_overflow  = inject && r == 32'd1;
        tx_underflow = inject && r == 32'd2;
    endtask

    initial begin
        errors       = 0;
        rx_left      = 0;
        tx_left      = 0;
        rst_n        = 1'b0;
        rx_beat      = '0;
        tx_beat      = '0;
        rx_bad_fcs   = 3'd0;
        tx_overflow  = 1'b0;
        tx_underflow = 1'b0;
        rx_aligned   = 1'b0;
        qsfp_fault   = 1'b0;
        repeat (5) @(negedge gt_init_clk);
        rst_n = 1'b1;

        // Down, up, fault, degraded, then down again with errors counted
        for (n = 0; n < 200; n++) drive_cycle(1'b1, 1'b0, 1'b0, 1'b0);
        for (n = 0; n < 200; n++) drive_cycle(1'b1, 1'b0, 1'b1, 1'b0);
        for (n = 0; n < 150; n++) drive_cycle(1'b1, 1'b0, 1'b1, 1'b1);
        for (n = 0; n < 250; n++) drive_cycle(1'b1, 1'b1, 1'b1, 1'b0);
        for (n = 0; n < 150; n++) drive_cycle(1'b1, 1'b1, 1'b0, 1'b0);

        for (n = 0; n < 300 && (rx_left != 0 || tx_left != 0); n++)
            drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
        if (rx_left != 0 || tx_left != 0) begin
            errors++;
            $display("Timeout: the streams did not finish their last packets");
        end
        for (n = 0; n < 20 && !monitors_idle; n++)
            drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);
        if (!monitors_idle) begin
            errors++;
            $display("Timeout: monitors_idle did not return high after traffic stopped");
        end
        drive_cycle(1'b0, 1'b0, 1'b0, 1'b0);

        $display("Checks finished with %0d errors", errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* tb.f */
hw/cmac_mon_pkg.sv
hw/cmac_rx_monitor.sv
hw/cmac_tx_monitor.sv
hw/link_status.sv
hw/cmac_link_monitor.sv
verification/tb_cmac_link_monitor.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_cmac_link_monitor
FILELIST   := tb.f
COMMON     := --timing --assert --timescale 1ns/1ps
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary -j 0 $(COMMON)
BUILD_DIR  := obj_dir
LOG        := sim.log
FAIL_MSG   := Simulation failed
PASS_MSG   := Simulation passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
